//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
RTL_TOP   ?= lsu_mem_top
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+sim
logic/lsu_pkg.sv
logic/axil_sram.sv
logic/lsu.sv
logic/lsu_mem_top.sv
sim/lsu_tb.sv

//--- logic/axil_sram.sv
`timescale 1ns/10ps
`default_nettype none

module axil_sram import lsu_pkg::*; #(
  parameter int unsigned depth_words = 1024,
  parameter logic [31:0] base_addr   = 32'h8000_0000
) (
  input  wire          clk,
  input  wire          rst,

  input  wire          ar_valid,
  input  wire axil_addr_t ar,
  output logic         ar_ready,

  output logic         r_valid,
  output axil_r_t      r,
  input  wire          r_ready,

  input  wire          aw_valid,
  input  wire axil_addr_t aw,
  output logic         aw_ready,

  input  wire          w_valid,
  input  wire axil_w_t w,
  output logic         w_ready,

  output logic         b_valid,
  output axil_b_t      b,
  input  wire          b_ready
);

  localparam int unsigned idx_w = (depth_words > 1) ? $clog2(depth_words) : 1;
  localparam logic [32:0] span  = 33'(depth_words) * 33'd4;  // bytes covered.

  typedef enum logic [1:0] {
    idle,
    read_resp,
    write_data,
    write_resp
  } state_e;

  state_e           state;
  logic [31:0]      mem [depth_words];
  axil_r_t          r_q;
  axil_b_t          b_q;
  logic             wr_ok;
  logic [idx_w-1:0] wr_idx;
  logic             rd_ok;
  logic [idx_w-1:0] rd_idx;
  logic             ar_fire;
  logic             aw_fire;
  logic             w_fire;

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  // low two address bits are ignored.
  function automatic logic addr_ok(input logic [31:0] a);
    logic [32:0] wa;
    wa = {1'b0, a[31:2], 2'b00};
    return (wa >= {1'b0, base_addr}) && (wa < {1'b0, base_addr} + span);
  endfunction

  function automatic logic [idx_w-1:0] addr_idx(input logic [31:0] a);
    logic [31:0] off;
    off = a - base_addr;
    return off[idx_w+1:2];
  endfunction

  assign rd_ok  = addr_ok(ar.addr);
  assign rd_idx = addr_idx(ar.addr);

  assign ar_fire = ar_valid && ar_ready;
  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;

  ////////////////////////////////////////////////////////////
  // slave fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (ar_fire)      state <= read_resp;
          else if (aw_fire) state <= write_data;
        end
        read_resp:  if (r_ready) state <= idle;
        write_data: if (w_valid) state <= write_resp;
        write_resp: if (b_ready) state <= idle;
        default:    state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      if (rd_ok) begin
        r_q <= '{data: mem[rd_idx], resp: resp_okay};
      end else begin
        r_q <= '{data: 32'h0, resp: resp_slverr};  // reads as zero.
      end
    end
    if (aw_fire) begin
      wr_ok  <= addr_ok(aw.addr);
      wr_idx <= addr_idx(aw.addr);
    end
    if (w_fire) begin
      b_q.resp <= wr_ok ? resp_okay : resp_slverr;
    end
  end

  // byte strobed write.
  always_ff @(posedge clk) begin
    if (w_fire && wr_ok) begin
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i]) mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
      end
    end
  end

  assign ar_ready = (state == idle);
  assign aw_ready = (state == idle) && !ar_valid;  // reads win a tie.
  assign w_ready  = (state == write_data);

  assign r_valid = (state == read_resp);
  assign r       = r_q;
  assign b_valid = (state == write_resp);
  assign b       = b_q;

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  a_r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid && !r_ready |=> r_valid && $stable(r));

  a_b_hold: assert property (@(posedge clk) disable iff (rst)
    b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

`default_nettype wire

//--- logic/lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu import lsu_pkg::*; (
  input  wire         clk,
  input  wire         rst,

  input  wire         req_valid,
  input  wire lsu_req_t req,
  output logic        req_ready,
  output logic        rsp_valid,
  output lsu_rsp_t    rsp,

  output logic        ar_valid,
  output axil_addr_t  ar,
  input  wire         ar_ready,

  input  wire         r_valid,
  input  wire axil_r_t r,
  output logic        r_ready,

  output logic        aw_valid,
  output axil_addr_t  aw,
  input  wire         aw_ready,

  output logic        w_valid,
  output axil_w_t     w,
  input  wire         w_ready,

  input  wire         b_valid,
  input  wire axil_b_t b,
  output logic        b_ready
);

  typedef enum logic [2:0] {
    idle,
    read_addr,
    read_data,
    write_addr,
    write_data,
    write_resp,
    respond
  } state_e;

  state_e      state;
  lsu_req_t    req_q;
  lsu_rsp_t    rsp_q;
  logic        req_fire;
  logic        r_fire;
  logic        b_fire;
  logic        misaligned;
  logic [1:0]  lane;
  logic [31:0] st_data;
  logic [3:0]  st_strb;
  logic [31:0] ld_shift;
  logic [31:0] ld_data;

  assign req_fire = req_valid && req_ready;
  assign r_fire   = r_valid && r_ready;
  assign b_fire   = b_valid && b_ready;

  ////////////////////////////////////////////////////////////
  // request check
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req.size)
      size_byte: misaligned = 1'b0;
      size_half: misaligned = req.addr[0];
      default:   misaligned = |req.addr[1:0];
    endcase
  end

  ////////////////////////////////////////////////////////////
  // store alignment and load extraction
  ////////////////////////////////////////////////////////////

  assign lane    = req_q.addr[1:0];
  assign st_data = req_q.wdata << {lane, 3'b000};  // move to byte lane.

  always_comb begin
    case (req_q.size)
      size_byte: st_strb = 4'b0001 << lane;
      size_half: st_strb = 4'b0011 << lane;
      default:   st_strb = 4'b1111;
    endcase
  end

  assign ld_shift = r.data >> {lane, 3'b000};

  always_comb begin
    case (req_q.size)
      size_byte: ld_data = {{24{req_q.sext & ld_shift[7]}}, ld_shift[7:0]};
      size_half: ld_data = {{16{req_q.sext & ld_shift[15]}}, ld_shift[15:0]};
      default:   ld_data = ld_shift;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // bus master fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (req_fire) begin
            if (misaligned)                state <= respond;  // no bus access.
            else if (req.op == op_store)   state <= write_addr;
            else                           state <= read_addr;
          end
        end
        read_addr:  if (ar_ready) state <= read_data;
        read_data:  if (r_fire) state <= respond;
        write_addr: if (aw_ready) state <= write_data;
        write_data: if (w_ready) state <= write_resp;
        write_resp: if (b_fire) state <= respond;
        default:    state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q <= req;
      rsp_q <= '{rdata: 32'h0, err: 1'b0, misaligned: misaligned};
    end
    if (r_fire) begin
      rsp_q.rdata <= ld_data;
      rsp_q.err   <= (r.resp == resp_slverr);
    end
    if (b_fire) begin
      rsp_q.err <= (b.resp == resp_slverr);
    end
  end

  assign req_ready = (state == idle);
  assign rsp_valid = (state == respond);
  assign rsp       = rsp_q;

  assign ar_valid = (state == read_addr);
  assign ar.addr  = req_q.addr;
  assign r_ready  = (state == read_data);

  assign aw_valid = (state == write_addr);
  assign aw.addr  = req_q.addr;
  assign w_valid  = (state == write_data);  // only after the aw transfer.
  assign w.data   = st_data;
  assign w.strb   = st_strb;
  assign b_ready  = (state == write_resp);

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar));

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw));

  a_rsp_pulse: assert property (@(posedge clk) disable iff (rst)
    rsp_valid |=> !rsp_valid);

endmodule

`default_nettype wire

//--- logic/lsu_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_mem_top import lsu_pkg::*; #(
  parameter int unsigned depth_words = 1024,
  parameter logic [31:0] base_addr   = 32'h8000_0000
) (
  input  wire           clk,
  input  wire           rst,
  input  wire           req_valid,
  input  wire lsu_req_t req,
  output logic          req_ready,
  output logic          rsp_valid,
  output lsu_rsp_t      rsp
);

  // internal axi-lite bus.
  logic       ar_valid, ar_ready;
  axil_addr_t ar;
  logic       r_valid, r_ready;
  axil_r_t    r;
  logic       aw_valid, aw_ready;
  axil_addr_t aw;
  logic       w_valid, w_ready;
  axil_w_t    w;
  logic       b_valid, b_ready;
  axil_b_t    b;

  lsu lsu_i (
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req(req), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp(rsp),
    .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
    .r_valid(r_valid), .r(r), .r_ready(r_ready),
    .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
    .w_valid(w_valid), .w(w), .w_ready(w_ready),
    .b_valid(b_valid), .b(b), .b_ready(b_ready)
  );

  axil_sram #(
    .depth_words(depth_words),
    .base_addr(base_addr)
  ) axil_sram_i (
    .clk(clk), .rst(rst),
    .ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
    .r_valid(r_valid), .r(r), .r_ready(r_ready),
    .aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
    .w_valid(w_valid), .w(w), .w_ready(w_ready),
    .b_valid(b_valid), .b(b), .b_ready(b_ready)
  );

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // core side encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_e;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } lsu_op_e;

  // axi response codes used here.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_e;

  typedef struct packed {
    lsu_op_e     op;
    mem_size_e   size;
    logic        sext;   // sign-extend loads.
    logic [31:0] addr;   // byte address.
    logic [31:0] wdata;  // store data in the low lanes.
  } lsu_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        misaligned;
  } lsu_rsp_t;

  ////////////////////////////////////////////////////////////
  // axi-lite channel payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0] addr;
  } axil_addr_t;  // shared by ar and aw.

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axil_w_t;

  typedef struct packed {
    logic [31:0] data;
    axil_resp_e  resp;
  } axil_r_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

endpackage

`default_nettype wire

//--- sim/lsu_tb_tasks.svh
localparam int unsigned mem_words  = 1024;
localparam logic [31:0] mem_base   = 32'h8000_0000;
localparam int unsigned wait_limit = 100;  // cycles per wait.

logic [7:0] shadow [4*mem_words];  // byte image of the sram.

////////////////////////////////////////////////////////////
// checking and bus driving
////////////////////////////////////////////////////////////

task automatic stop_run(input string why);
  $display("Simulation FAILED");
  $fatal(1, "%s", why);
endtask

task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
  if (act !== exp) begin
    $display("FAIL at %0t ns: %s, got %h, expected %h", $time, msg, act, exp);
    stop_run("value mismatch");
  end
endtask

task automatic do_req(input lsu_req_t rq, output lsu_rsp_t rs);
  int unsigned n;
  @(posedge clk);
  req_valid <= 1'b1;
  req       <= rq;
  n = 0;
  @(negedge clk);  // outputs are settled here.
  while (!req_ready) begin
    n = n + 1;
    if (n > wait_limit) begin
      $display("timeout while waiting for req_ready after %0d cycles", wait_limit);
      stop_run("request was never accepted");
    end
    @(negedge clk);
  end
  @(posedge clk);  // accepted on this edge.
  req_valid <= 1'b0;
  n = 0;
  @(negedge clk);
  while (!rsp_valid) begin
    check(32'(req_ready), 32'd0, "req_ready high while a request is in flight");
    n = n + 1;
    if (n > wait_limit) begin
      $display("timeout while waiting for rsp_valid after %0d cycles", wait_limit);
      stop_run("response never came");
    end
    @(negedge clk);
  end
  check(32'(req_ready), 32'd0, "req_ready high during the response");
  rs = rsp;
endtask

function automatic lsu_req_t make_req(input lsu_op_e op, input mem_size_e size,
                                      input logic sext, input logic [31:0] addr,
                                      input logic [31:0] wdata);
  return '{op: op, size: size, sext: sext, addr: addr, wdata: wdata};
endfunction

////////////////////////////////////////////////////////////
// shadow memory
////////////////////////////////////////////////////////////

task automatic model_store(input logic [31:0] addr, input mem_size_e size,
                           input logic [31:0] data);
  logic [11:0] o;
  int unsigned nb;
  o  = 12'(addr - mem_base);
  nb = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
  for (int i = 0; i < nb; i++) begin
    shadow[o + 12'(i)] = data[8*i +: 8];  // low bytes of wdata land at addr.
  end
endtask

function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_size_e size,
                                           input logic sext);
  logic [11:0] o;
  logic [15:0] h;
  o = 12'(addr - mem_base);
  h = {shadow[o + 12'd1], shadow[o]};
  case (size)
    size_byte: return sext ? 32'($signed(shadow[o])) : 32'(shadow[o]);
    size_half: return sext ? 32'($signed(h)) : 32'(h);
    default:   return {shadow[o + 12'd3], shadow[o + 12'd2], h};
  endcase
endfunction

// start pattern for the words of the random sequence.
function automatic logic [31:0] fill_word(input logic [31:0] a);
  return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
endfunction

task automatic do_store(input mem_size_e size, input logic [31:0] addr,
                        input logic [31:0] data);
  lsu_rsp_t rs;
  do_req(make_req(op_store, size, 1'b0, addr, data), rs);
  check(32'(rs.err), 32'd0, $sformatf("store err at %h", addr));
  check(32'(rs.misaligned), 32'd0, $sformatf("store misaligned at %h", addr));
  model_store(addr, size, data);
endtask

task automatic load_expect(input mem_size_e size, input logic sext, input logic [31:0] addr,
                           input logic [31:0] exp);
  lsu_rsp_t rs;
  do_req(make_req(op_load, size, sext, addr, 32'h0), rs);
  check(32'(rs.err), 32'd0, $sformatf("load err at %h", addr));
  check(32'(rs.misaligned), 32'd0, $sformatf("load misaligned at %h", addr));
  check(rs.rdata, exp, $sformatf("load data at %h", addr));
endtask

task automatic load_and_compare(input mem_size_e size, input logic sext,
                                input logic [31:0] addr);
  load_expect(size, sext, addr, model_load(addr, size, sext));
endtask

task automatic expect_flags(input lsu_req_t rq, input logic err, input logic mis,
                            output lsu_rsp_t rs);
  do_req(rq, rs);
  check(32'(rs.err), 32'(err), $sformatf("err flag at %h", rq.addr));
  check(32'(rs.misaligned), 32'(mis), $sformatf("misaligned flag at %h", rq.addr));
endtask

////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////

task automatic test_word_round_trip();
  do_store(size_word, mem_base, 32'hdead_beef);
  load_expect(size_word, 1'b0, mem_base, 32'hdead_beef);
endtask

task automatic test_partial_stores();
  do_store(size_word, mem_base + 4, 32'h1122_3344);
  do_store(size_half, mem_base + 6, 32'h5555_ccdd);  // upper bits must not leak.
  do_store(size_byte, mem_base + 5, 32'hffff_ffaa);
  do_store(size_byte, mem_base + 7, 32'h0000_00bb);
  load_expect(size_word, 1'b0, mem_base + 4, 32'hbbdd_aa44);
endtask

task automatic test_load_extension();
  do_store(size_word, mem_base + 8, 32'h7f80_c3a5);
  load_expect(size_byte, 1'b1, mem_base + 8, 32'hffff_ffa5);
  load_expect(size_byte, 1'b0, mem_base + 8, 32'h0000_00a5);
  load_expect(size_byte, 1'b1, mem_base + 11, 32'h0000_007f);
  load_expect(size_byte, 1'b0, mem_base + 11, 32'h0000_007f);
  load_expect(size_byte, 1'b1, mem_base + 10, 32'hffff_ff80);
  load_expect(size_half, 1'b1, mem_base + 8, 32'hffff_c3a5);
  load_expect(size_half, 1'b0, mem_base + 8, 32'h0000_c3a5);
  load_expect(size_half, 1'b1, mem_base + 10, 32'h0000_7f80);
  load_expect(size_half, 1'b0, mem_base + 10, 32'h0000_7f80);
endtask

task automatic test_out_of_range();
  lsu_rsp_t    rs;
  logic [31:0] bad;
  bad = mem_base + 4 * mem_words;  // first byte past the sram.
  expect_flags(make_req(op_load, size_word, 1'b0, bad, 32'h0), 1'b1, 1'b0, rs);
  check(rs.rdata, 32'h0, "out of range load data");
  expect_flags(make_req(op_store, size_word, 1'b0, bad, 32'h1234_5678), 1'b1, 1'b0, rs);
  load_and_compare(size_word, 1'b0, mem_base);
endtask

task automatic test_misaligned();
  lsu_rsp_t rs;
  expect_flags(make_req(op_store, size_half, 1'b0, mem_base + 9, 32'h0000_ffff),
               1'b0, 1'b1, rs);
  expect_flags(make_req(op_load, size_word, 1'b0, mem_base + 10, 32'h0), 1'b0, 1'b1, rs);
  load_and_compare(size_word, 1'b0, mem_base + 8);
endtask

task automatic test_random_sequence();
  int unsigned widx;
  int unsigned lane;
  int unsigned pick;
  mem_size_e   sz;
  logic [31:0] addr;
  for (int i = 16; i < 32; i++) begin
    do_store(size_word, mem_base + 4 * i, fill_word(mem_base + 4 * i));
  end
  for (int n = 0; n < 200; n++) begin
    widx = 16 + $urandom_range(15, 0);
    pick = $urandom_range(2, 0);
    sz   = (pick == 0) ? size_byte : (pick == 1) ? size_half : size_word;
    lane = (sz == size_byte) ? $urandom_range(3, 0) :
           (sz == size_half) ? 2 * $urandom_range(1, 0) : 0;
    addr = mem_base + (4 * widx) + lane;
    if ($urandom_range(1, 0) != 0) do_store(sz, addr, $urandom());
    else                           load_and_compare(sz, $urandom_range(1, 0) != 0, addr);
  end
endtask

//--- sim/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  logic     clk;
  logic     rst;
  logic     req_valid;
  lsu_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  lsu_rsp_t rsp;

  `include "lsu_tb_tasks.svh"

  always #4 clk = ~clk;  // 8 ns period.

  lsu_mem_top lsu_mem_top_i (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req(req),
    .req_ready(req_ready),
    .rsp_valid(rsp_valid),
    .rsp(rsp)
  );

  initial begin
    void'($urandom(32'h66b3_b347));
    clk       = 1'b0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    test_word_round_trip();
    test_partial_stores();
    test_load_extension();
    test_out_of_range();
    test_misaligned();
    test_random_sequence();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
